/* common/dcachePkg.sv */
package dcachePkg;

  // cache geometry
  localparam int AddrWidth    = 32;
  localparam int WordWidth    = 64;
  localparam int LineWidth    = 256;
  localparam int NumSets      = 64;
  localparam int NumWays      = 2;
  localparam int OffsetBits   = 5;
  localparam int IndexBits    = 6;
  localparam int TagBits      = 21;
  localparam int WordsPerLine = 4;
  localparam int BytesPerWord = 8;

  // one full cache line
  typedef logic [LineWidth-1:0] lineT;

  // way number inside a set
  typedef logic wayT;

  // address split into its cache fields
  typedef struct packed {
    logic [TagBits-1:0]   tag;
    logic [IndexBits-1:0] index;
    logic [1:0]           wordSel;
    logic [2:0]           byteOff;
  } addrFieldsT;

  // same address word, seen raw or as fields
  typedef union packed {
    logic [AddrWidth-1:0] raw;
    addrFieldsT           fields;
  } cacheAddrT;

  // processor side request
  typedef struct packed {
    logic                    write;
    cacheAddrT               addr;
    logic [WordWidth-1:0]    wdata;
    logic [BytesPerWord-1:0] mask;
  } coreReqT;

  // line-wide memory bus request
  typedef struct packed {
    logic      write;
    cacheAddrT addr;
    lineT      wline;
  } memReqT;

endpackage

/* dcache/tagStore.sv */
module tagStore (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic [dcachePkg::IndexBits-1:0]   index_i,
  input  logic [dcachePkg::TagBits-1:0]     tag_i,
  input  logic                              install_i,
  input  dcachePkg::wayT                    installWay_i,
  input  logic                              markDirty_i,
  input  dcachePkg::wayT                    dirtyWay_i,
  output logic                              hit_o,
  output dcachePkg::wayT                    hitWay_o,
  output dcachePkg::wayT                    victimWay_o,
  output logic                              victimDirty_o,
  output logic [dcachePkg::TagBits-1:0]     victimTag_o
);

  logic [dcachePkg::NumSets-1:0]    validArr [dcachePkg::NumWays];
  logic [dcachePkg::NumSets-1:0]    dirtyArr [dcachePkg::NumWays];
  logic [dcachePkg::TagBits-1:0]    tagArr   [dcachePkg::NumWays][dcachePkg::NumSets];
  logic [dcachePkg::NumWays-1:0]    wayHit;
  logic                             replBit;

  // compare both ways of the set
  always_comb begin
    for (int w = 0; w < dcachePkg::NumWays; w++) begin
      wayHit[w] = validArr[w][index_i] && (tagArr[w][index_i] == tag_i);
    end
  end

  assign hit_o    = |wayHit;
  assign hitWay_o = wayHit[1];

  // victim is whatever way the toggle bit points at
  assign victimWay_o   = replBit;
  assign victimDirty_o = validArr[replBit][index_i] && dirtyArr[replBit][index_i];
  assign victimTag_o   = tagArr[replBit][index_i];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int w = 0; w < dcachePkg::NumWays; w++) begin
        validArr[w] <= '0;
        dirtyArr[w] <= '0;
      end
      replBit <= 1'b0;
    end else begin
      if (install_i) begin
        validArr[installWay_i][index_i] <= 1'b1;
        dirtyArr[installWay_i][index_i] <= 1'b0;
        replBit                         <= ~replBit;
      end else if (markDirty_i) begin
        dirtyArr[dirtyWay_i][index_i] <= 1'b1;
      end
    end
  end

  // tags follow the valid bit
  always_ff @(posedge clk) begin
    if (install_i) begin
      tagArr[installWay_i][index_i] <= tag_i;
    end
  end

endmodule

/* dcache/dataStore.sv */
module dataStore (
  input  logic                                     clk,
  input  logic [dcachePkg::IndexBits-1:0]          index_i,
  input  logic                                     wrEn_i,
  input  dcachePkg::wayT                           wrWay_i,
  input  logic [dcachePkg::LineWidth/8-1:0]        wrMask_i,
  input  dcachePkg::lineT                          wrLine_i,
  output dcachePkg::lineT [dcachePkg::NumWays-1:0] wayLines_o
);

  dcachePkg::lineT lineMem [dcachePkg::NumWays][dcachePkg::NumSets];

  // byte enable write, full mask on refill
  always_ff @(posedge clk) begin
    if (wrEn_i) begin
      for (int b = 0; b < dcachePkg::LineWidth / 8; b++) begin
        if (wrMask_i[b]) begin
          lineMem[wrWay_i][index_i][b*8 +: 8] <= wrLine_i[b*8 +: 8];
        end
      end
    end
  end

  // registered read of both ways
  always_ff @(posedge clk) begin
    for (int w = 0; w < dcachePkg::NumWays; w++) begin
      wayLines_o[w] <= lineMem[w][index_i];
    end
  end

endmodule

/* dcache/dcacheCtrl.sv */
module dcacheCtrl (
  input  logic                                         clk,
  input  logic                                         rst_n,
  input  dcachePkg::coreReqT                           coreReq_i,
  input  logic                                         coreReqValid_i,
  input  logic                                         hit_i,
  input  dcachePkg::wayT                               hitWay_i,
  input  dcachePkg::wayT                               victimWay_i,
  input  logic                                         victimDirty_i,
  input  logic [dcachePkg::TagBits-1:0]                victimTag_i,
  input  dcachePkg::lineT [dcachePkg::NumWays-1:0]     wayLines_i,
  input  logic                                         evictDone_i,
  input  logic                                         fillDone_i,
  input  dcachePkg::lineT                              fillLine_i,
  output logic                                         coreAck_o,
  output logic [dcachePkg::WordWidth-1:0]              coreRdata_o,
  output logic [dcachePkg::IndexBits-1:0]              index_o,
  output dcachePkg::wayT                               wrWay_o,
  output logic                                         wrEn_o,
  output logic [dcachePkg::LineWidth/8-1:0]            wrMask_o,
  output dcachePkg::lineT                              wrLine_o,
  output logic                                         install_o,
  output logic                                         markDirty_o,
  output logic                                         evictStart_o,
  output dcachePkg::cacheAddrT                         evictAddr_o,
  output dcachePkg::lineT                              evictLine_o,
  output logic                                         fillStart_o,
  output dcachePkg::cacheAddrT                         fillAddr_o
);

  typedef enum logic [2:0] {
    Idle, Lookup, Compare, Evict, Fill, Install, Done
  } stateT;

  stateT                                                     state;
  dcachePkg::coreReqT                                        reqQ;
  logic [dcachePkg::WordsPerLine-1:0][dcachePkg::WordWidth-1:0] hitWords;
  logic [dcachePkg::BytesPerWord-1:0]                        wordMask;
  logic [dcachePkg::WordWidth-1:0]                           wordData;
  logic [dcachePkg::LineWidth/8-1:0]                         storeMask;
  logic                                                      storeHit;
  logic                                                      missNow;

  assign index_o  = reqQ.addr.fields.index;
  assign hitWords = wayLines_i[hitWay_i];
  assign storeHit = (state == Compare) && hit_i && reqQ.write;
  assign missNow  = (state == Compare) && !hit_i;

  // store data and byte enables placed into the addressed word
  assign wordMask  = reqQ.mask << reqQ.addr.fields.byteOff;
  assign wordData  = reqQ.wdata << {reqQ.addr.fields.byteOff, 3'b000};
  assign storeMask = wordMask << {reqQ.addr.fields.wordSel, 3'b000};

  assign install_o   = (state == Install);
  assign markDirty_o = storeHit;
  assign wrEn_o      = storeHit || install_o;
  assign wrWay_o     = install_o ? victimWay_i : hitWay_i;
  assign wrMask_o    = install_o ? '1 : storeMask;
  assign wrLine_o    = install_o ? fillLine_i : {dcachePkg::WordsPerLine{wordData}};

  // dirty victim goes out before the refill
  assign evictStart_o = missNow && victimDirty_i;
  assign evictLine_o  = wayLines_i[victimWay_i];
  assign fillStart_o  = (missNow && !victimDirty_i) || ((state == Evict) && evictDone_i);

  always_comb begin
    evictAddr_o              = '0;
    evictAddr_o.fields.tag   = victimTag_i;
    evictAddr_o.fields.index = reqQ.addr.fields.index;
    fillAddr_o               = '0;
    fillAddr_o.fields.tag    = reqQ.addr.fields.tag;
    fillAddr_o.fields.index  = reqQ.addr.fields.index;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= Idle;
      coreAck_o <= 1'b0;
    end else begin
      case (state)
        Idle: if (coreReqValid_i) state <= Lookup;
        // data store read in flight
        Lookup: state <= Compare;
        Compare: begin
          if (hit_i) begin
            coreAck_o <= 1'b1;
            state     <= Done;
          end else if (victimDirty_i) begin
            state <= Evict;
          end else begin
            state <= Fill;
          end
        end
        Evict: if (evictDone_i) state <= Fill;
        Fill: if (fillDone_i) state <= Install;
        // repeat the lookup, it hits now
        Install: state <= Lookup;
        Done: begin
          if (!coreReqValid_i) begin
            coreAck_o <= 1'b0;
            state     <= Idle;
          end
        end
        default: state <= Idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == Idle && coreReqValid_i) begin
      reqQ <= coreReq_i;
    end
    if (state == Compare && hit_i) begin
      coreRdata_o <= hitWords[reqQ.addr.fields.wordSel];
    end
  end

endmodule

/* hw/evictEngine.sv */
module evictEngine (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 start_i,
  input  dcachePkg::cacheAddrT addr_i,
  input  dcachePkg::lineT      line_i,
  input  logic                 grantAck_i,
  output dcachePkg::memReqT    busReq_o,
  output logic                 busReqValid_o,
  output logic                 done_o
);

  dcachePkg::cacheAddrT addrQ;
  dcachePkg::lineT      lineQ;
  logic                 waitFall;

  // victim copy, the set may be refilled after this
  always_ff @(posedge clk) begin
    if (start_i) begin
      addrQ.raw <= {addr_i.raw[dcachePkg::AddrWidth-1:dcachePkg::OffsetBits],
                    {dcachePkg::OffsetBits{1'b0}}};
      lineQ     <= line_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busReqValid_o <= 1'b0;
      waitFall      <= 1'b0;
      done_o        <= 1'b0;
    end else begin
      done_o <= 1'b0;
      if (start_i) begin
        busReqValid_o <= 1'b1;
      end else if (busReqValid_o && grantAck_i) begin
        busReqValid_o <= 1'b0;
        waitFall      <= 1'b1;
      end else if (waitFall && !grantAck_i) begin
        waitFall <= 1'b0;
        done_o   <= 1'b1;
      end
    end
  end

  assign busReq_o = '{write: 1'b1, addr: addrQ, wline: lineQ};

endmodule

/* hw/fillEngine.sv */
module fillEngine (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 start_i,
  input  dcachePkg::cacheAddrT addr_i,
  input  logic                 grantAck_i,
  input  dcachePkg::lineT      grantRdata_i,
  output dcachePkg::memReqT    busReq_o,
  output logic                 busReqValid_o,
  output logic                 done_o,
  output dcachePkg::lineT      line_o
);

  dcachePkg::cacheAddrT addrQ;
  logic                 waitFall;

  always_ff @(posedge clk) begin
    if (start_i) begin
      addrQ.raw <= {addr_i.raw[dcachePkg::AddrWidth-1:dcachePkg::OffsetBits],
                    {dcachePkg::OffsetBits{1'b0}}};
    end
    // read line is valid for as long as ack is up
    if (grantAck_i) begin
      line_o <= grantRdata_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busReqValid_o <= 1'b0;
      waitFall      <= 1'b0;
      done_o        <= 1'b0;
    end else begin
      done_o <= 1'b0;
      if (start_i) begin
        busReqValid_o <= 1'b1;
      end else if (busReqValid_o && grantAck_i) begin
        busReqValid_o <= 1'b0;
        waitFall      <= 1'b1;
      end else if (waitFall && !grantAck_i) begin
        waitFall <= 1'b0;
        done_o   <= 1'b1;
      end
    end
  end

  assign busReq_o = '{write: 1'b0, addr: addrQ, wline: '0};

endmodule

/* hw/memArbiter.sv */
module memArbiter (
  input  logic              clk,
  input  logic              rst_n,
  input  dcachePkg::memReqT evictReq_i,
  input  logic              evictValid_i,
  input  dcachePkg::memReqT fillReq_i,
  input  logic              fillValid_i,
  input  logic              memAck_i,
  input  dcachePkg::lineT   memRdata_i,
  output dcachePkg::memReqT memReq_o,
  output logic              memReqValid_o,
  output logic              evictAck_o,
  output logic              fillAck_o,
  output dcachePkg::lineT   fillRdata_o
);

  logic locked;
  logic selFill;
  logic ackSeen;

  // grant held from request until the ack has fallen
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      locked  <= 1'b0;
      selFill <= 1'b0;
      ackSeen <= 1'b0;
    end else if (!locked) begin
      ackSeen <= 1'b0;
      if (fillValid_i) begin
        locked  <= 1'b1;
        selFill <= 1'b1;
      end else if (evictValid_i) begin
        locked  <= 1'b1;
        selFill <= 1'b0;
      end
    end else if (memAck_i) begin
      ackSeen <= 1'b1;
    end else if (ackSeen) begin
      locked  <= 1'b0;
      ackSeen <= 1'b0;
    end
  end

  assign memReq_o      = selFill ? fillReq_i : evictReq_i;
  assign memReqValid_o = locked && (selFill ? fillValid_i : evictValid_i);
  assign evictAck_o    = locked && !selFill && memAck_i;
  assign fillAck_o     = locked && selFill && memAck_i;
  assign fillRdata_o   = memRdata_i;

endmodule

/* hw/dcacheTop.sv */
module dcacheTop (
  input  logic                            clk,
  input  logic                            rst_n,
  input  dcachePkg::coreReqT              coreReq_i,
  input  logic                            coreReqValid_i,
  output logic                            coreAck_o,
  output logic [dcachePkg::WordWidth-1:0] coreRdata_o,
  output dcachePkg::memReqT               memReq_o,
  output logic                            memReqValid_o,
  input  logic                            memAck_i,
  input  dcachePkg::lineT                 memRdata_i
);

  logic                                     hit;
  dcachePkg::wayT                           hitWay;
  dcachePkg::wayT                           victimWay;
  logic                                     victimDirty;
  logic [dcachePkg::TagBits-1:0]            victimTag;
  dcachePkg::lineT [dcachePkg::NumWays-1:0] wayLines;
  logic [dcachePkg::IndexBits-1:0]          index;
  dcachePkg::wayT                           wrWay;
  logic                                     wrEn;
  logic [dcachePkg::LineWidth/8-1:0]        wrMask;
  dcachePkg::lineT                          wrLine;
  logic                                     install;
  logic                                     markDirty;
  logic                                     evictStart;
  logic                                     fillStart;
  logic                                     evictDone;
  logic                                     fillDone;
  dcachePkg::cacheAddrT                     evictAddr;
  dcachePkg::cacheAddrT                     fillAddr;
  dcachePkg::lineT                          evictLine;
  dcachePkg::lineT                          fillLine;
  dcachePkg::lineT                          fillRdata;
  dcachePkg::memReqT                        evictReq;
  dcachePkg::memReqT                        fillReq;
  logic                                     evictValid;
  logic                                     fillValid;
  logic                                     evictAck;
  logic                                     fillAck;

  dcacheCtrl uCtrl (
    .clk, .rst_n, .coreReq_i, .coreReqValid_i,
    .hit_i(hit), .hitWay_i(hitWay), .victimWay_i(victimWay),
    .victimDirty_i(victimDirty), .victimTag_i(victimTag), .wayLines_i(wayLines),
    .evictDone_i(evictDone), .fillDone_i(fillDone), .fillLine_i(fillLine),
    .coreAck_o, .coreRdata_o, .index_o(index), .wrWay_o(wrWay), .wrEn_o(wrEn),
    .wrMask_o(wrMask), .wrLine_o(wrLine), .install_o(install), .markDirty_o(markDirty),
    .evictStart_o(evictStart), .evictAddr_o(evictAddr), .evictLine_o(evictLine),
    .fillStart_o(fillStart), .fillAddr_o(fillAddr)
  );

  // latched request tag, carried on the fill address
  tagStore uTags (
    .clk, .rst_n, .index_i(index), .tag_i(fillAddr.fields.tag),
    .install_i(install), .installWay_i(wrWay), .markDirty_i(markDirty),
    .dirtyWay_i(wrWay), .hit_o(hit), .hitWay_o(hitWay), .victimWay_o(victimWay),
    .victimDirty_o(victimDirty), .victimTag_o(victimTag)
  );

  dataStore uData (
    .clk, .index_i(index), .wrEn_i(wrEn), .wrWay_i(wrWay), .wrMask_i(wrMask),
    .wrLine_i(wrLine), .wayLines_o(wayLines)
  );

  evictEngine uEvict (
    .clk, .rst_n, .start_i(evictStart), .addr_i(evictAddr), .line_i(evictLine),
    .grantAck_i(evictAck), .busReq_o(evictReq), .busReqValid_o(evictValid),
    .done_o(evictDone)
  );

  fillEngine uFill (
    .clk, .rst_n, .start_i(fillStart), .addr_i(fillAddr), .grantAck_i(fillAck),
    .grantRdata_i(fillRdata), .busReq_o(fillReq), .busReqValid_o(fillValid),
    .done_o(fillDone), .line_o(fillLine)
  );

  memArbiter uArb (
    .clk, .rst_n, .evictReq_i(evictReq), .evictValid_i(evictValid),
    .fillReq_i(fillReq), .fillValid_i(fillValid), .memAck_i, .memRdata_i,
    .memReq_o, .memReqValid_o, .evictAck_o(evictAck), .fillAck_o(fillAck),
    .fillRdata_o(fillRdata)
  );

endmodule

/* bench/memResponder.sv */
module memResponder (
  input  logic                 clk,
  input  logic                 rst_n,
  input  dcachePkg::memReqT    memReq_i,
  input  logic                 memReqValid_i,
  output logic                 memAck_o,
  output dcachePkg::lineT      memRdata_o,
  output logic                 wbValid_o,
  output dcachePkg::cacheAddrT wbAddr_o,
  output dcachePkg::lineT      wbLine_o
);
  timeunit 1ns;
  timeprecision 100ps;

  // backing store keyed by line number, only bus writes land here
  dcachePkg::lineT backing [logic [26:0]];
  logic            busy;
  int unsigned     delay;

  // background content, every address bit takes part
  function automatic logic [7:0] backgroundByte(input logic [31:0] a);
    return a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24] ^ {a[4:0], a[7:5]} ^ 8'h96;
  endfunction

  function automatic dcachePkg::lineT readLine(input logic [31:0] lineAddr);
    dcachePkg::lineT l;
    if (backing.exists(lineAddr[31:5])) begin
      return backing[lineAddr[31:5]];
    end
    for (int b = 0; b < 32; b++) begin
      l[b*8 +: 8] = backgroundByte(lineAddr + 32'(b));
    end
    return l;
  endfunction

  initial begin
    memAck_o   = 1'b0;
    memRdata_o = '0;
    wbValid_o  = 1'b0;
    wbAddr_o   = '0;
    wbLine_o   = '0;
  end

  // ack after a random wait, drop it once req has gone
  always @(negedge clk or negedge rst_n) begin
    if (!rst_n) begin
      memAck_o  <= 1'b0;
      busy      <= 1'b0;
      delay     <= 0;
      wbValid_o <= 1'b0;
    end else begin
      wbValid_o <= 1'b0;
      if (memAck_o) begin
        if (!memReqValid_i) begin
          memAck_o <= 1'b0;
        end
      end else if (memReqValid_i) begin
        if (!busy) begin
          busy  <= 1'b1;
          delay <= $urandom_range(0, 4);
        end else if (delay != 0) begin
          delay <= delay - 1;
        end else begin
          busy     <= 1'b0;
          memAck_o <= 1'b1;
          if (memReq_i.write) begin
            backing[memReq_i.addr.raw[31:5]] = memReq_i.wline;
            wbValid_o <= 1'b1;
            wbAddr_o  <= memReq_i.addr;
            wbLine_o  <= memReq_i.wline;
          end else begin
            memRdata_o <= readLine(memReq_i.addr.raw);
          end
        end
      end
    end
  end

endmodule

/* bench/tbDcache.sv */
module tbDcache;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int          RandomOps      = 300;
  localparam int          PairCount      = 100;
  localparam int          TotalOps       = RandomOps + 2 * PairCount;
  localparam int          ClkPeriod      = 8;
  localparam int          WatchdogCycles = (TotalOps + 10) * 200;
  localparam logic [20:0] TagBase        = 21'h0d2c0;

  logic                 clk;
  logic                 rst_n;
  dcachePkg::coreReqT   coreReq;
  logic                 coreReqValid;
  logic                 coreAck;
  logic [63:0]          coreRdata;
  dcachePkg::memReqT    memReq;
  logic                 memReqValid;
  logic                 memAck;
  dcachePkg::lineT      memRdata;
  logic                 wbValid;
  dcachePkg::cacheAddrT wbAddr;
  dcachePkg::lineT      wbLine;

  // golden bytes for 3 tags x 4 sets, 32 bytes per line
  logic [7:0]           goldMem [0:383];
  logic                 lineDirty [0:11];
  int                   errorCount;
  int                   checkCount;
  int                   testCount;
  logic                 lastReq;
  logic                 lastAck;
  dcachePkg::cacheAddrT prevAddr;

  dcacheTop UUT (
    .clk, .rst_n, .coreReq_i(coreReq), .coreReqValid_i(coreReqValid),
    .coreAck_o(coreAck), .coreRdata_o(coreRdata), .memReq_o(memReq),
    .memReqValid_o(memReqValid), .memAck_i(memAck), .memRdata_i(memRdata)
  );

  memResponder mem (
    .clk, .rst_n, .memReq_i(memReq), .memReqValid_i(memReqValid),
    .memAck_o(memAck), .memRdata_o(memRdata), .wbValid_o(wbValid),
    .wbAddr_o(wbAddr), .wbLine_o(wbLine)
  );

  initial clk = 1'b0;
  always #(ClkPeriod / 2) clk = ~clk;

  function automatic logic [7:0] backgroundByte(input logic [31:0] a);
    return a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24] ^ {a[4:0], a[7:5]} ^ 8'h96;
  endfunction

  function automatic dcachePkg::cacheAddrT makeAddr(input int tagSel, input int setSel,
                                                    input int wordSel);
    dcachePkg::cacheAddrT a;
    a.raw            = '0;
    a.fields.tag     = TagBase + 21'(tagSel);
    a.fields.index   = 6'(setSel * 16 + 3);
    a.fields.wordSel = 2'(wordSel);
    return a;
  endfunction

  function automatic dcachePkg::cacheAddrT randomAddr();
    return makeAddr($urandom_range(0, 2), $urandom_range(0, 3), $urandom_range(0, 3));
  endfunction

  function automatic logic inWindow(input dcachePkg::cacheAddrT a);
    return ((a.fields.tag - TagBase) < 21'd3) && (a.fields.index[3:0] == 4'd3);
  endfunction

  function automatic int lineOf(input dcachePkg::cacheAddrT a);
    return int'(a.fields.tag - TagBase) * 4 + int'(a.fields.index[5:4]);
  endfunction

  function automatic logic [63:0] goldWord(input dcachePkg::cacheAddrT a);
    logic [63:0] w;
    int          base;
    base = lineOf(a) * 32 + int'(a.fields.wordSel) * 8;
    for (int i = 0; i < 8; i++) begin
      w[i*8 +: 8] = goldMem[base + i];
    end
    return w;
  endfunction

  function automatic dcachePkg::lineT goldLine(input int id);
    dcachePkg::lineT l;
    for (int b = 0; b < 32; b++) begin
      l[b*8 +: 8] = goldMem[id * 32 + b];
    end
    return l;
  endfunction

  function automatic logic [63:0] byteMask(input logic [7:0] m);
    logic [63:0] bits;
    for (int i = 0; i < 8; i++) begin
      bits[i*8 +: 8] = {8{m[i]}};
    end
    return bits;
  endfunction

  task automatic initGolden();
    dcachePkg::cacheAddrT base;
    for (int t = 0; t < 3; t++) begin
      for (int s = 0; s < 4; s++) begin
        base = makeAddr(t, s, 0);
        lineDirty[t * 4 + s] = 1'b0;
        for (int b = 0; b < 32; b++) begin
          goldMem[(t * 4 + s) * 32 + b] = backgroundByte(base.raw + 32'(b));
        end
      end
    end
  endtask

  // one four-phase exchange, called on a falling edge
  task automatic access(input logic isWrite, input dcachePkg::cacheAddrT addr,
                        input logic [63:0] wdata, input logic [7:0] mask,
                        output logic [63:0] rdata, output int cycles, output logic sawMem);
    coreReq      <= '{write: isWrite, addr: addr, wdata: wdata, mask: mask};
    coreReqValid <= 1'b1;
    cycles = 0;
    sawMem = 1'b0;
    do begin
      @(negedge clk);
      cycles++;
      if (memReqValid) begin
        sawMem = 1'b1;
      end
    end while (!coreAck);
    rdata = coreRdata;
    coreReqValid <= 1'b0;
    do @(negedge clk); while (coreAck);
    prevAddr = addr;
  endtask

  // first sampling edge is one negedge after the drive
  task automatic checkHitTiming(input int cycles, input logic sawMem);
    checkCount++;
    assert (cycles - 1 == 2) else begin
      $display("Fail coreAck_o latency expected %h actual %h", 2, cycles - 1);
      errorCount++;
    end
    checkCount++;
    assert (!sawMem) else begin
      $display("a memory request was issued during a repeated access that should hit");
      errorCount++;
    end
  endtask

  task automatic loadAndCheck(input dcachePkg::cacheAddrT addr, input logic isRepeat);
    logic [63:0] expWord;
    logic [63:0] rdata;
    int          cycles;
    logic        sawMem;
    expWord = goldWord(addr);
    access(1'b0, addr, '0, '0, rdata, cycles, sawMem);
    checkCount++;
    assert (rdata === expWord) else begin
      $display("Fail coreRdata_o expected %h actual %h", expWord, rdata);
      errorCount++;
    end
    if (isRepeat) begin
      checkHitTiming(cycles, sawMem);
    end
  endtask

  task automatic storeWord(input dcachePkg::cacheAddrT addr, input logic [63:0] wdata,
                           input logic [7:0] mask, input logic isRepeat);
    logic [63:0] rdata;
    int          cycles;
    logic        sawMem;
    int          base;
    access(1'b1, addr, wdata, mask, rdata, cycles, sawMem);
    base = lineOf(addr) * 32 + int'(addr.fields.wordSel) * 8;
    for (int i = 0; i < 8; i++) begin
      if (mask[i]) begin
        goldMem[base + i] = wdata[i*8 +: 8];
      end
    end
    // a hit store marks the line dirty even with an empty mask
    lineDirty[lineOf(addr)] = 1'b1;
    if (isRepeat) begin
      checkHitTiming(cycles, sawMem);
    end
  endtask

  task automatic checkIdle();
    checkCount++;
    assert (coreAck === 1'b0) else begin
      $display("Fail coreAck_o expected %h actual %h", 1'b0, coreAck);
      errorCount++;
    end
    checkCount++;
    assert (memReqValid === 1'b0) else begin
      $display("Fail memReqValid_o expected %h actual %h", 1'b0, memReqValid);
      errorCount++;
    end
  endtask

  task automatic checkWriteback();
    logic okAddr;
    int   id;
    okAddr = (wbAddr.raw[4:0] == 5'd0) && inWindow(wbAddr);
    checkCount++;
    assert (okAddr) else begin
      $display("writeback to %h is not a line address that the test touched", wbAddr.raw);
      errorCount++;
    end
    if (okAddr) begin
      id = lineOf(wbAddr);
      checkCount++;
      assert (lineDirty[id]) else begin
        $display("unexpected writeback of line %h, it was not stored to", wbAddr.raw);
        errorCount++;
      end
      checkCount++;
      assert (wbLine === goldLine(id)) else begin
        $display("Fail memReq_o.wline expected %h actual %h", goldLine(id), wbLine);
        errorCount++;
      end
      lineDirty[id] = 1'b0;
    end
  endtask

  task automatic reportTest(input string name, input int startErrors);
    testCount++;
    $display("test %s done, %0d errors", name, errorCount - startErrors);
  endtask

  // writebacks reported by the memory model
  always @(posedge clk) begin
    if (rst_n && wbValid) begin
      checkWriteback();
    end
  end

  // core handshake, transition across the previous edge
  always @(posedge clk) begin
    if (!rst_n) begin
      lastReq <= 1'b0;
      lastAck <= 1'b0;
    end else begin
      if (coreAck && !lastAck) begin
        assert (lastReq) else begin
          $display("coreAck_o rose while no request was pending");
          errorCount++;
        end
      end
      if (lastAck && !lastReq) begin
        assert (!coreAck) else begin
          $display("coreAck_o stayed high after the request was sampled low");
          errorCount++;
        end
      end
      if (lastAck && lastReq) begin
        assert (coreAck) else begin
          $display("coreAck_o fell while the request was still high");
          errorCount++;
        end
      end
      lastReq <= coreReqValid;
      lastAck <= coreAck;
    end
  end

  initial begin
    #(WatchdogCycles * ClkPeriod);
    $display("watchdog expired after %0d cycles, the DUT stopped responding", WatchdogCycles);
    $display("ERRORS FOUND");
    $finish;
  end

  initial begin
    int                   startErrors;
    dcachePkg::cacheAddrT addr;
    logic                 rep;
    logic [63:0]          oldWord;
    logic [63:0]          wdata;
    logic [63:0]          rdata;
    logic [63:0]          expWord;
    logic [7:0]           mask;
    int                   cycles;
    logic                 sawMem;
    void'($urandom(32'hf395df87));
    rst_n        = 1'b0;
    coreReqValid = 1'b0;
    coreReq      = '0;
    errorCount   = 0;
    checkCount   = 0;
    testCount    = 0;
    initGolden();

    // quiet during reset and a few cycles after
    startErrors = errorCount;
    repeat (3) begin
      @(negedge clk);
      checkIdle();
    end
    rst_n <= 1'b1;
    repeat (5) begin
      @(negedge clk);
      checkIdle();
    end
    reportTest("reset", startErrors);

    // conflicting window of 3 tags x 4 sets
    startErrors = errorCount;
    for (int n = 0; n < RandomOps; n++) begin
      rep = (n > 0) && ($urandom_range(0, 3) == 0);
      if (rep) begin
        addr = prevAddr;
      end else begin
        addr = randomAddr();
      end
      if ($urandom_range(0, 1) == 1) begin
        storeWord(addr, {$urandom, $urandom}, 8'($urandom), rep);
      end else begin
        loadAndCheck(addr, rep);
      end
    end
    reportTest("random traffic", startErrors);

    // masked store, then read back the same word
    startErrors = errorCount;
    for (int n = 0; n < PairCount; n++) begin
      addr    = randomAddr();
      oldWord = goldWord(addr);
      wdata   = {$urandom, $urandom};
      mask    = 8'($urandom);
      storeWord(addr, wdata, mask, 1'b0);
      expWord = (oldWord & ~byteMask(mask)) | (wdata & byteMask(mask));
      access(1'b0, addr, '0, '0, rdata, cycles, sawMem);
      checkCount++;
      assert (rdata === expWord) else begin
        $display("Fail coreRdata_o expected %h actual %h", expWord, rdata);
        errorCount++;
      end
      checkHitTiming(cycles, sawMem);
    end
    reportTest("masked store and load", startErrors);

    $display("summary: %0d tests, %0d checks, %0d errors", testCount, checkCount, errorCount);
    if (errorCount == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

/* build.f */
common/dcachePkg.sv
dcache/tagStore.sv
dcache/dataStore.sv
dcache/dcacheCtrl.sv
hw/evictEngine.sv
hw/fillEngine.sv
hw/memArbiter.sv
hw/dcacheTop.sv
bench/memResponder.sv
bench/tbDcache.sv

/* Bender.yml */
package:
  name: dcache

sources:
  - common/dcachePkg.sv
  - dcache/tagStore.sv
  - dcache/dataStore.sv
  - dcache/dcacheCtrl.sv
  - hw/evictEngine.sv
  - hw/fillEngine.sv
  - hw/memArbiter.sv
  - hw/dcacheTop.sv
  - target: test
    files:
      - bench/memResponder.sv
      - bench/tbDcache.sv
